/* include/ex_defines.svh */
// Width macros for the execute stage, included by the package and by RTL that sizes slices
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data path width
`define EX_XLEN 32

// Register file write address, 64 entries
`define EX_RADDR_W 6

// Shift amount taken from operand b
`define EX_SHAMT_W 5

// Opcode widths
`define EX_ALU_OP_W 4
`define EX_MUL_OP_W 2

`endif

/* design/ex_pkg.sv */
// Shared types of the execute stage, imported by every RTL module and the unit interface
`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

  // Data and address widths
  typedef logic [`EX_XLEN-1:0]   word_t;
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t;
  typedef logic [2*`EX_XLEN-1:0] dword_t;

  // ALU operations, the last six are branch compares
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [`EX_MUL_OP_W-1:0] {
    MUL_MUL    = 2'b00,
    MUL_MULH   = 2'b01,
    MUL_MULHSU = 2'b10,
    MUL_MULHU  = 2'b11
  } mul_op_e;

  // High-half multiply sequencing
  typedef enum logic {
    MULT_IDLE   = 1'b0,
    MULT_FINISH = 1'b1
  } mult_state_e;

endpackage

`default_nettype wire

/* design/ex_unit_if.sv */
// Result bundle from the ALU and multiplier to the writeback block, instanced in the stage top
`timescale 1ns/1ps
`default_nettype none

interface ex_unit_if import ex_pkg::*; ();

  // ALU side
  word_t alu_result;
  logic  alu_cmp;

  // Multiplier side
  word_t mult_result;
  logic  mult_ready;

  // ALU drives its result and branch flag
  modport alu_src (
    output alu_result,
    output alu_cmp
  );

  // Multiplier drives its result and readiness
  modport mult_src (
    output mult_result,
    output mult_ready
  );

  // Writeback consumes everything as plain levels
  modport sink (
    input alu_result,
    input alu_cmp,
    input mult_result,
    input mult_ready
  );

endinterface

`default_nettype wire

/* design/ex_alu.sv */
// Combinational integer ALU with branch compare, instanced once inside the execute stage
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_alu import ex_pkg::*; (
  input  alu_op_e         operator_i,
  input  word_t           operand_a_i,
  input  word_t           operand_b_i,
  ex_unit_if.alu_src      unit_o
);

  // Shared arithmetic terms
  logic [`EX_SHAMT_W-1:0] shamt;
  word_t                  sum;
  word_t                  diff;
  logic                   is_equal;
  logic                   lt_signed;
  logic                   lt_unsigned;

  // Low bits of operand b only
  assign shamt = operand_b_i[`EX_SHAMT_W-1:0];

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Compare terms, reused by SLT and branches
  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb begin
    // Branch compares leave the result at zero
    unit_o.alu_result = '0;
    case (operator_i)
      ALU_ADD:  unit_o.alu_result = sum;
      ALU_SUB:  unit_o.alu_result = diff;
      ALU_AND:  unit_o.alu_result = operand_a_i & operand_b_i;
      ALU_OR:   unit_o.alu_result = operand_a_i | operand_b_i;
      ALU_XOR:  unit_o.alu_result = operand_a_i ^ operand_b_i;
      ALU_SLL:  unit_o.alu_result = operand_a_i << shamt;
      ALU_SRL:  unit_o.alu_result = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:  unit_o.alu_result = word_t'($signed(operand_a_i) >>> shamt);
      // Set-less-than lands in bit 0
      ALU_SLT:  unit_o.alu_result = word_t'(lt_signed);
      ALU_SLTU: unit_o.alu_result = word_t'(lt_unsigned);
      default:  unit_o.alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Branch decision
  //////////////////////////////////////////////////

  always_comb begin
    // Non-branch ops never take a branch
    unit_o.alu_cmp = 1'b0;
    case (operator_i)
      ALU_EQ:  unit_o.alu_cmp = is_equal;
      ALU_NE:  unit_o.alu_cmp = ~is_equal;
      ALU_LT:  unit_o.alu_cmp = lt_signed;
      ALU_GE:  unit_o.alu_cmp = ~lt_signed;
      ALU_LTU: unit_o.alu_cmp = lt_unsigned;
      ALU_GEU: unit_o.alu_cmp = ~lt_unsigned;
      default: unit_o.alu_cmp = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* design/ex_mult.sv */
// Integer multiplier of the execute stage, single cycle for MUL and two cycles for high halves
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_mult import ex_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  mul_op_e           operator_i,
  input  word_t             op_a_i,
  input  word_t             op_b_i,
  input  logic              ex_ready_i,
  output logic              multicycle_o,
  ex_unit_if.mult_src       unit_o
);

  // Operand signedness per opcode
  logic                           sign_a;
  logic                           sign_b;
  logic signed [`EX_XLEN:0]       op_a_ext;
  logic signed [`EX_XLEN:0]       op_b_ext;
  logic signed [2*`EX_XLEN+1:0]   product_full;
  dword_t                         product;

  // Sequencing
  logic                           start_high;
  mult_state_e                    state_q;
  mult_state_e                    state_d;
  word_t                          high_q;

  //////////////////////////////////////////////////
  // Product
  //////////////////////////////////////////////////

  // MULH signed x signed, MULHSU signed x unsigned
  assign sign_a = (operator_i == MUL_MULH) | (operator_i == MUL_MULHSU);
  assign sign_b = (operator_i == MUL_MULH);

  // One extra bit turns every mode into a signed multiply
  assign op_a_ext = {sign_a & op_a_i[`EX_XLEN-1], op_a_i};
  assign op_b_ext = {sign_b & op_b_i[`EX_XLEN-1], op_b_i};

  assign product_full = op_a_ext * op_b_ext;
  assign product      = product_full[2*`EX_XLEN-1:0];

  // A high-half op starts only from idle
  assign start_high = enable_i & (operator_i != MUL_MUL) & (state_q == MULT_IDLE);

  //////////////////////////////////////////////////
  // Two-state controller
  //////////////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    unit_o.mult_ready  = 1'b1;
    multicycle_o       = 1'b0;
    // MUL and idle cycles show the low half directly
    unit_o.mult_result = product[`EX_XLEN-1:0];
    case (state_q)
      MULT_IDLE: begin
        if (start_high) begin
          // Stall the stage while the product is captured
          unit_o.mult_ready = 1'b0;
          state_d           = MULT_FINISH;
        end
      end
      MULT_FINISH: begin
        multicycle_o       = 1'b1;
        unit_o.mult_result = high_q;
        // Hold under back-pressure
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // High half held until the stage moves on
  always_ff @(posedge clk) begin
    if (start_high) begin
      high_q <= product[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

endmodule

`default_nettype wire

/* design/ex_writeback.sv */
// Write port muxing, EX/WB register and stall logic of the execute stage, fed by the unit interface
`timescale 1ns/1ps
`default_nettype none

module ex_writeback import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        alu_en_i,
  input  logic        mult_en_i,
  input  logic        csr_access_i,
  input  logic        lsu_en_i,
  input  logic        regfile_alu_we_i,
  input  logic        regfile_we_i,
  input  logic        lsu_err_i,
  input  logic        lsu_ready_ex_i,
  input  logic        wb_ready_i,
  input  logic        branch_in_ex_i,
  input  reg_addr_t   regfile_alu_waddr_i,
  input  reg_addr_t   regfile_waddr_i,
  input  word_t       csr_rdata_i,
  input  word_t       lsu_rdata_i,
  ex_unit_if.sink     unit_i,
  output logic        regfile_alu_we_fw_o,
  output reg_addr_t   regfile_alu_waddr_fw_o,
  output word_t       regfile_alu_wdata_fw_o,
  output logic        regfile_we_wb_o,
  output reg_addr_t   regfile_waddr_wb_o,
  output word_t       regfile_wdata_wb_o,
  output logic        ex_ready_o,
  output logic        ex_valid_o
);

  // EX/WB state for the LSU port
  logic      regfile_we_lsu_q;
  reg_addr_t regfile_waddr_lsu_q;
  logic      lsu_we_next;
  logic      units_ready;

  //////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = unit_i.mult_result;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = unit_i.alu_result;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  //////////////////////////////////////////////////
  // LSU port and EX/WB register
  //////////////////////////////////////////////////

  // A faulting access never reaches the register file
  assign lsu_we_next = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu_q    <= 1'b0;
      regfile_waddr_lsu_q <= '0;
    end else if (ex_valid_o) begin
      regfile_we_lsu_q <= lsu_we_next;
      if (lsu_we_next) begin
        regfile_waddr_lsu_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new arrived, flush the old write
      regfile_we_lsu_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = regfile_we_lsu_q;
  assign regfile_waddr_wb_o = regfile_waddr_lsu_q;
  // Load data arrives from the LSU in the WB cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  assign units_ready = unit_i.mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve here and skip the WB handshake
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

`default_nettype wire

/* design/ex_stage.sv */
// Execute stage top with ALU, multiplier and writeback, exposing plain pipeline ports
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // ALU operation from decode
  input  alu_op_e   alu_operator_i,
  input  word_t     alu_operand_a_i,
  input  word_t     alu_operand_b_i,
  input  logic      alu_en_i,

  // Multiplier operation from decode
  input  mul_op_e   mult_operator_i,
  input  word_t     mult_operand_a_i,
  input  word_t     mult_operand_b_i,
  input  logic      mult_en_i,
  output logic      mult_multicycle_o,

  // Load/store unit
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,

  // Register file targets
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,

  // CSR read data
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,

  // LSU write port to WB
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o,

  // Forwarding port to decode
  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output word_t     regfile_alu_wdata_fw_o,

  // Branch resolution to fetch
  input  logic      branch_in_ex_i,
  input  word_t     jump_target_i,
  output word_t     jump_target_o,
  output logic      branch_decision_o,

  // Handshake
  input  logic      wb_ready_i,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  // Unit results toward writeback
  ex_unit_if unit_if ();

  // Target computed in decode, decision here
  assign jump_target_o     = jump_target_i;
  assign branch_decision_o = unit_if.alu_cmp;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  ex_alu alu_i (
    .operator_i  (alu_operator_i),
    .operand_a_i (alu_operand_a_i),
    .operand_b_i (alu_operand_b_i),
    .unit_o      (unit_if.alu_src)
  );

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////

  // Stage ready lets the high-half FSM retire
  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .multicycle_o (mult_multicycle_o),
    .unit_o       (unit_if.mult_src)
  );

  //////////////////////////////////////////////////
  // Writeback and stall
  //////////////////////////////////////////////////

  ex_writeback wb_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_we_i           (regfile_we_i),
    .lsu_err_i              (lsu_err_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .unit_i                 (unit_if.sink),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

/* test/ex_stage_assertions.sv */
// Concurrent checks on the execute stage handshake and LSU port, bound into the stage top
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assertions (
  input logic clk,
  input logic rst_n,
  input logic regfile_we_wb_o,
  input logic branch_in_ex_i,
  input logic ex_ready_o,
  input logic ex_valid_o,
  input logic wb_ready_i,
  input logic mult_multicycle_o
);

  // Failed assertions, read by the testbench at the end
  int unsigned failures = 0;

  //////////////////////////////////////////////////
  // Reset and handshake
  //////////////////////////////////////////////////

  // LSU port comes out of reset empty
  assert property (@(posedge clk) $rose(rst_n) |-> !regfile_we_wb_o)
    else begin
      failures++;
      $error("LSU write enable high in the first cycle after reset");
    end

  // Branches never stall the stage
  assert property (@(posedge clk) disable iff (!rst_n) branch_in_ex_i |-> ex_ready_o)
    else begin
      failures++;
      $error("Stage not ready while a branch is in EX");
    end

  // No valid result without writeback ready
  assert property (@(posedge clk) disable iff (!rst_n) ex_valid_o |-> wb_ready_i)
    else begin
      failures++;
      $error("Stage valid while writeback is not ready");
    end

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////

  // High-half result retires once the stage moves on
  assert property (@(posedge clk) disable iff (!rst_n)
                   (mult_multicycle_o && ex_ready_o) |=> !mult_multicycle_o)
    else begin
      failures++;
      $error("Multicycle flag still high after the stage accepted the result");
    end

endmodule

`default_nettype wire

/* test/ex_stage_tb.sv */
// Self-checking testbench for the execute stage, replays the case file one step per line
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb import ex_pkg::*; ();

  // DUT inputs
  logic      clk;
  logic      rst_n;
  alu_op_e   alu_operator_i;
  word_t     alu_operand_a_i;
  word_t     alu_operand_b_i;
  logic      alu_en_i;
  mul_op_e   mult_operator_i;
  word_t     mult_operand_a_i;
  word_t     mult_operand_b_i;
  logic      mult_en_i;
  logic      lsu_en_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      branch_in_ex_i;
  word_t     jump_target_i;
  logic      wb_ready_i;

  // DUT outputs
  logic      mult_multicycle_o;
  logic      regfile_we_wb_o;
  reg_addr_t regfile_waddr_wb_o;
  word_t     regfile_wdata_wb_o;
  logic      regfile_alu_we_fw_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  word_t     regfile_alu_wdata_fw_o;
  word_t     jump_target_o;
  logic      branch_decision_o;
  logic      ex_ready_o;
  logic      ex_valid_o;

  // Fields of the current case line
  string     cases_q[$];
  string     cur_test;
  string     cur_kind;
  logic [3:0] c_aop;
  logic [1:0] c_mop;
  word_t     c_a;
  word_t     c_b;
  logic [3:0] c_en;
  logic      c_awe;
  reg_addr_t c_aaddr;
  logic      c_rwe;
  reg_addr_t c_raddr;
  word_t     c_csr;
  word_t     c_lsu;
  logic [2:0] c_ctl;
  word_t     e_data;
  reg_addr_t e_addr;
  logic      e_flag;
  logic      e_rdy;
  logic      e_vld;

  // Run bookkeeping
  int        cycle_count;
  int        cycle_limit;

  ex_stage dut (.*);

  bind ex_stage ex_stage_assertions assertions_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .regfile_we_wb_o   (regfile_we_wb_o),
    .branch_in_ex_i    (branch_in_ex_i),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .wb_ready_i        (wb_ready_i),
    .mult_multicycle_o (mult_multicycle_o)
  );

  //////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("test failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: %s expected %h, got %h", cur_test, what, expected, actual);
      abort_run("word mismatch");
    end
  endtask

  task automatic check_addr(input string what, input reg_addr_t expected,
                            input reg_addr_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: %s expected %h, got %h", cur_test, what, expected, actual);
      abort_run("address mismatch");
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s: %s expected %b, got %b", cur_test, what, expected, actual);
      abort_run("flag mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Case file and stimulus
  //////////////////////////////////////////////////

  // Keeps every non-comment line, so the case count is known up front
  task automatic load_cases();
    int    fd;
    string line;
    fd = $fopen("test/ex_stage_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file test/ex_stage_cases.txt");
      abort_run("missing case file");
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0 && line.len() > 4 && line.getc(0) != "#") begin
        cases_q.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  task automatic parse_case(input string line);
    int n;
    n = $sscanf(line, "%s %s %h %h %h %h %b %b %h %b %h %h %h %b %h %h %b %b %b",
                cur_test, cur_kind, c_aop, c_mop, c_a, c_b, c_en, c_awe, c_aaddr,
                c_rwe, c_raddr, c_csr, c_lsu, c_ctl, e_data, e_addr, e_flag, e_rdy, e_vld);
    if (n != 19) begin
      $display("Case line has %0d fields instead of 19: %s", n, line);
      abort_run("malformed case line");
    end
  endtask

  // Same operands feed the ALU and the multiplier
  task automatic drive_step();
    alu_operator_i      = alu_op_e'(c_aop);
    mult_operator_i     = mul_op_e'(c_mop);
    alu_operand_a_i     = c_a;
    alu_operand_b_i     = c_b;
    mult_operand_a_i    = c_a;
    mult_operand_b_i    = c_b;
    {alu_en_i, mult_en_i, csr_access_i, lsu_en_i} = c_en;
    regfile_alu_we_i    = c_awe;
    regfile_alu_waddr_i = c_aaddr;
    regfile_we_i        = c_rwe;
    regfile_waddr_i     = c_raddr;
    csr_rdata_i         = c_csr;
    lsu_rdata_i         = c_lsu;
    {lsu_err_i, wb_ready_i, branch_in_ex_i} = c_ctl;
    jump_target_i       = {c_a[15:0], c_b[15:0]};
  endtask

  task automatic check_handshake(input string phase);
    check_bit({"ex_ready_o ", phase}, e_rdy, ex_ready_o);
    check_bit({"ex_valid_o ", phase}, e_vld, ex_valid_o);
  endtask

  //////////////////////////////////////////////////
  // Step runner
  //////////////////////////////////////////////////

  // Drive after the rising edge, sample at the falling edge
  task automatic run_case(input string line);
    parse_case(line);
    @(posedge clk);
    #1;
    drive_step();
    @(negedge clk);
    case (cur_kind)
      "comb": begin
        check_word("regfile_alu_wdata_fw_o", e_data, regfile_alu_wdata_fw_o);
        check_bit("regfile_alu_we_fw_o", c_awe, regfile_alu_we_fw_o);
        check_addr("regfile_alu_waddr_fw_o", c_aaddr, regfile_alu_waddr_fw_o);
        check_bit("branch_decision_o", e_flag, branch_decision_o);
        check_bit("mult_multicycle_o", 1'b0, mult_multicycle_o);
        check_handshake("");
      end
      "br": begin
        check_bit("branch_decision_o", e_flag, branch_decision_o);
        check_word("jump_target_o", {c_a[15:0], c_b[15:0]}, jump_target_o);
        check_handshake("");
      end
      "mulh": begin
        // Stage stalls first, then the high half shows up
        check_handshake("at start");
        while (ex_ready_o !== 1'b1) begin
          @(negedge clk);
        end
        check_word("regfile_alu_wdata_fw_o", e_data, regfile_alu_wdata_fw_o);
        check_bit("mult_multicycle_o", e_flag, mult_multicycle_o);
      end
      "lsu": begin
        check_handshake("");
        // EX/WB register output one edge later
        @(negedge clk);
        check_bit("regfile_we_wb_o", e_flag, regfile_we_wb_o);
        if (e_flag) begin
          check_addr("regfile_waddr_wb_o", e_addr, regfile_waddr_wb_o);
        end
        check_word("regfile_wdata_wb_o", e_data, regfile_wdata_wb_o);
      end
      default: begin
        $display("Case %s has an unknown kind %s", cur_test, cur_kind);
        abort_run("unknown case kind");
      end
    endcase
  endtask

  //////////////////////////////////////////////////
  // Clock, watchdog and main sequence
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Limit scales with the number of case lines
  initial begin
    cycle_count = 0;
    @(posedge clk);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run hung: no end of test within %0d cycles", cycle_limit);
    abort_run("timeout");
  end

  initial begin
    rst_n       = 1'b0;
    cur_test    = "reset";
    cur_kind    = "";
    c_a         = '0;
    c_b         = '0;
    c_aop       = '0;
    c_mop       = '0;
    c_en        = '0;
    c_awe       = 1'b0;
    c_aaddr     = '0;
    c_rwe       = 1'b0;
    c_raddr     = '0;
    c_csr       = '0;
    c_lsu       = '0;
    // Idle pipeline with writeback ready
    c_ctl       = 3'b010;
    drive_step();
    lsu_ready_ex_i = 1'b1;
    load_cases();
    cycle_limit = cases_q.size() * 4 + 20;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (cases_q[i]) begin
      run_case(cases_q[i]);
    end
    @(negedge clk);
    if (dut.assertions_i.failures == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("Assertion failures: %0d", dut.assertions_i.failures);
      abort_run("checks failed");
    end
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
design/ex_pkg.sv
design/ex_unit_if.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_writeback.sv
design/ex_stage.sv
test/ex_stage_assertions.sv
test/ex_stage_tb.sv

/* test/ex_stage_cases.txt */
# name kind alu_op mul_op a b en(alu,mul,csr,lsu) alu_we alu_waddr rf_we rf_waddr csr lsu_rdata
# ctl(lsu_err,wb_ready,branch) then expected: data wb_addr flag ready valid
add      comb 0 0 00000005 00000003 1000 1 01 0 00 00000000 00000000 010 00000008 00 0 1 1
sub      comb 1 0 00000003 00000005 1000 1 02 0 00 00000000 00000000 010 fffffffe 00 0 1 1
and      comb 2 0 f0f0ff00 0ff0f0f0 1000 1 03 0 00 00000000 00000000 010 00f0f000 00 0 1 1
xor      comb 4 0 aaaa5555 ffff0000 1000 1 04 0 00 00000000 00000000 010 55555555 00 0 1 1
sll      comb 5 0 00000001 00000024 1000 1 05 0 00 00000000 00000000 010 00000010 00 0 1 1
sra      comb 7 0 80000000 00000004 1000 1 06 0 00 00000000 00000000 010 f8000000 00 0 1 1
srl      comb 6 0 80000000 0000001f 1000 1 07 0 00 00000000 00000000 010 00000001 00 0 1 1
slt      comb 8 0 ffffffff 00000001 1000 1 08 0 00 00000000 00000000 010 00000001 00 0 1 1
sltu     comb 9 0 ffffffff 00000001 1000 1 09 0 00 00000000 00000000 010 00000000 00 0 1 1
mul      comb 0 0 00000007 fffffffd 0100 1 0a 0 00 00000000 00000000 010 ffffffeb 00 0 1 1
fwd_csr  comb 0 0 00000002 00000003 1110 1 0b 0 00 cafef00d 00000000 010 cafef00d 00 0 1 1
fwd_mul  comb 0 0 00000006 00000007 1100 1 0c 0 00 00000000 00000000 010 0000002a 00 0 1 1
beq_t    br   a 0 12345678 12345678 0000 0 00 0 00 00000000 00000000 011 00000000 00 1 1 0
bne_f    br   b 0 12345678 12345678 0000 0 00 0 00 00000000 00000000 011 00000000 00 0 1 0
blt_t    br   c 0 80000000 00000001 0000 0 00 0 00 00000000 00000000 011 00000000 00 1 1 0
bge_t    br   d 0 00000001 80000000 0000 0 00 0 00 00000000 00000000 011 00000000 00 1 1 0
bltu_f   br   e 0 80000000 00000001 0000 0 00 0 00 00000000 00000000 011 00000000 00 0 1 0
bgeu_wbn br   f 0 80000000 00000001 0000 0 00 0 00 00000000 00000000 001 00000000 00 1 1 0
mulh     mulh 0 1 fffffffe 00000003 0100 1 0d 0 00 00000000 00000000 010 ffffffff 00 1 0 0
mulhsu   mulh 0 2 fffffffe ffffffff 0100 1 0e 0 00 00000000 00000000 010 fffffffe 00 1 0 0
mulhu    mulh 0 3 80000000 00000004 0100 1 0f 0 00 00000000 00000000 010 00000002 00 1 0 0
ld_ok    lsu  0 0 00000000 00000000 0001 0 00 1 15 00000000 deadbeef 010 deadbeef 15 1 1 1
ld_wbn   lsu  0 0 00000000 00000000 0001 0 00 1 3f 00000000 11223344 000 11223344 15 1 0 0
ld_err   lsu  0 0 00000000 00000000 0001 0 00 1 2a 00000000 0badf00d 110 0badf00d 00 0 1 1
ld_ok2   lsu  0 0 00000000 00000000 0001 0 00 1 07 00000000 55aa55aa 010 55aa55aa 07 1 1 1
ld_flush lsu  0 0 00000000 00000000 0000 0 00 1 3f 00000000 99887766 010 99887766 00 0 1 0
